// File: src/core_pkg.sv
package core_pkg;

    typedef logic [31:0]  instr_t;
    typedef logic [31:0]  data_t;
    typedef logic [3:0]   reg_idx_t;
    typedef logic [127:0] line_t;
    typedef logic [15:0]  imm_t;
    typedef logic [4:0]   count_t; // holds 0 to 16 entries.

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_addi = 4'd6,
        op_lui  = 4'd7
    } opcode_e;

    localparam int default_depth = 16;

    function automatic opcode_e instr_op(instr_t instr);
        return instr[31] ? op_nop : opcode_e'(instr[31:28]); // codes 8 to 15 are undefined.
    endfunction

    function automatic reg_idx_t instr_rd(instr_t instr);
        return instr[27:24];
    endfunction

    function automatic reg_idx_t instr_rs1(instr_t instr);
        return instr[23:20];
    endfunction

    function automatic reg_idx_t instr_rs2(instr_t instr);
        return instr[19:16];
    endfunction

    function automatic imm_t instr_imm(instr_t instr);
        return instr[15:0];
    endfunction

endpackage

// File: src/fetch_buffer.sv
`timescale 1ns/100ps

module fetch_buffer #(
    parameter int depth = core_pkg::default_depth
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             line_valid,
    input  core_pkg::line_t  line,
    input  logic [1:0]       issue_count,
    output core_pkg::instr_t head0,
    output core_pkg::instr_t head1,
    output logic             head0_valid,
    output logic             head1_valid,
    output logic             full
);
    import core_pkg::*;

    instr_t entry      [depth];
    instr_t entry_next [depth];
    count_t count;
    count_t survivors;
    count_t count_next;
    logic   accept;

    assign accept     = line_valid && !full;
    assign survivors  = count - count_t'(issue_count);
    assign count_next = accept ? survivors + count_t'(4) : survivors;

    // the head drops first, then the new line lands right behind what is left.
    always_comb begin
        for (int i = 0; i < depth; i++) begin
            if (i + int'(issue_count) < depth) begin
                entry_next[i] = entry[i + int'(issue_count)];
            end else begin
                entry_next[i] = entry[i];
            end
        end
        if (accept) begin
            for (int k = 0; k < 4; k++) begin
                if (int'(survivors) + k < depth) begin
                    entry_next[int'(survivors) + k] = line[32*k +: 32]; // word 0 is oldest.
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        entry <= entry_next;
    end

    assign head0       = entry[0];
    assign head1       = entry[1];
    assign head0_valid = count > count_t'(0);
    assign head1_valid = count > count_t'(1);
    assign full        = count > count_t'(depth - 4); // a whole line no longer fits.

    a_no_strobe_when_full : assert property (
        @(posedge clk) disable iff (!rstn) line_valid |-> !full
    ) else $error("line strobed while the fetch queue is full");

    a_issue_within_count : assert property (
        @(posedge clk) disable iff (!rstn) count_t'(issue_count) <= count
    ) else $error("issue count exceeds queue occupancy");

endmodule

// File: src/issue_decode.sv
`timescale 1ns/100ps

module issue_decode (
    input  core_pkg::instr_t   head0,
    input  core_pkg::instr_t   head1,
    input  logic               head0_valid,
    input  logic               head1_valid,
    input  logic               hold,
    input  core_pkg::data_t    rdata_1a,
    input  core_pkg::data_t    rdata_2a,
    input  core_pkg::data_t    rdata_1b,
    input  core_pkg::data_t    rdata_2b,
    output logic [1:0]         issue_count,
    output core_pkg::reg_idx_t rs1_a,
    output core_pkg::reg_idx_t rs2_a,
    output core_pkg::reg_idx_t rs1_b,
    output core_pkg::reg_idx_t rs2_b,
    output logic               valid_a,
    output logic               valid_b,
    output core_pkg::opcode_e  op_a,
    output core_pkg::opcode_e  op_b,
    output core_pkg::reg_idx_t rd_a,
    output core_pkg::reg_idx_t rd_b,
    output core_pkg::data_t    x_a,
    output core_pkg::data_t    y_a,
    output core_pkg::data_t    x_b,
    output core_pkg::data_t    y_b
);
    import core_pkg::*;

    logic writes_a;
    logic dep_b;

    function automatic logic is_reg_reg(opcode_e op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor};
    endfunction

    function automatic data_t second_operand(opcode_e op, data_t rdata, imm_t imm);
        case (op)
            op_addi: return {{16{imm[15]}}, imm};
            op_lui:  return {imm, 16'h0000};
            default: return rdata;
        endcase
    endfunction

    assign op_a  = instr_op(head0);
    assign rd_a  = instr_rd(head0);
    assign rs1_a = instr_rs1(head0);
    assign rs2_a = instr_rs2(head0);
    assign op_b  = instr_op(head1);
    assign rd_b  = instr_rd(head1);
    assign rs1_b = instr_rs1(head1);
    assign rs2_b = instr_rs2(head1);

    assign x_a = rdata_1a;
    assign y_a = second_operand(op_a, rdata_2a, instr_imm(head0));
    assign x_b = rdata_1b;
    assign y_b = second_operand(op_b, rdata_2b, instr_imm(head1));

    assign writes_a = (op_a != op_nop) && (rd_a != '0);
    assign dep_b    = writes_a && ((rs1_b == rd_a) || (is_reg_reg(op_b) && (rs2_b == rd_a)));

    always_comb begin
        if (hold || !head0_valid) begin
            issue_count = 2'd0;
        end else if (head1_valid && !dep_b) begin
            issue_count = 2'd2;
        end else begin
            issue_count = 2'd1; // the younger one waits for a forward next cycle.
        end
    end

    assign valid_a = issue_count != 2'd0;
    assign valid_b = issue_count == 2'd2;

endmodule

// File: src/alu_execute.sv
`timescale 1ns/100ps

module alu_execute (
    input  logic               clk,
    input  logic               rstn,
    input  logic               valid_a,
    input  logic               valid_b,
    input  core_pkg::opcode_e  op_a,
    input  core_pkg::opcode_e  op_b,
    input  core_pkg::reg_idx_t rd_a,
    input  core_pkg::reg_idx_t rd_b,
    input  core_pkg::data_t    x_a,
    input  core_pkg::data_t    y_a,
    input  core_pkg::data_t    x_b,
    input  core_pkg::data_t    y_b,
    output logic               ex0_valid,
    output core_pkg::reg_idx_t ex0_rd,
    output core_pkg::data_t    ex0_data,
    output logic               ex1_valid,
    output core_pkg::reg_idx_t ex1_rd,
    output core_pkg::data_t    ex1_data
);
    import core_pkg::*;

    data_t res_a;
    data_t res_b;
    logic  wr_a;
    logic  wr_b;

    function automatic data_t alu(opcode_e op, data_t x, data_t y);
        case (op)
            op_add, op_addi: return x + y;
            op_sub:          return x - y;
            op_and:          return x & y;
            op_or:           return x | y;
            op_xor:          return x ^ y;
            op_lui:          return y;
            default:         return '0;
        endcase
    endfunction

    assign res_a = alu(op_a, x_a, y_a);
    assign res_b = alu(op_b, x_b, y_b);
    assign wr_a  = valid_a && (op_a != op_nop) && (rd_a != '0);
    assign wr_b  = valid_b && (op_b != op_nop) && (rd_b != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex0_valid <= 1'b0;
            ex1_valid <= 1'b0;
        end else begin
            ex0_valid <= wr_a || wr_b;
            ex1_valid <= wr_a && wr_b;
        end
    end

    // a lone younger writer moves down into slot 0.
    always_ff @(posedge clk) begin
        if (wr_a) begin
            ex0_rd   <= rd_a;
            ex0_data <= res_a;
        end else begin
            ex0_rd   <= rd_b;
            ex0_data <= res_b;
        end
        ex1_rd   <= rd_b;
        ex1_data <= res_b;
    end

    a_slot1_needs_slot0 : assert property (
        @(posedge clk) disable iff (!rstn) valid_b |-> valid_a
    ) else $error("slot 1 issued without slot 0");

endmodule

// File: src/reg_result.sv
`timescale 1ns/100ps

module reg_result (
    input  logic               clk,
    input  logic               rstn,
    input  logic               ex0_valid,
    input  core_pkg::reg_idx_t ex0_rd,
    input  core_pkg::data_t    ex0_data,
    input  logic               ex1_valid,
    input  core_pkg::reg_idx_t ex1_rd,
    input  core_pkg::data_t    ex1_data,
    input  core_pkg::reg_idx_t rs1_a,
    input  core_pkg::reg_idx_t rs2_a,
    input  core_pkg::reg_idx_t rs1_b,
    input  core_pkg::reg_idx_t rs2_b,
    output core_pkg::data_t    rdata_1a,
    output core_pkg::data_t    rdata_2a,
    output core_pkg::data_t    rdata_1b,
    output core_pkg::data_t    rdata_2b,
    output logic               wb0_valid,
    output core_pkg::reg_idx_t wb0_rd,
    output core_pkg::data_t    wb0_data,
    output logic               wb1_valid,
    output core_pkg::reg_idx_t wb1_rd,
    output core_pkg::data_t    wb1_data
);
    import core_pkg::*;

    data_t regs [16];

    function automatic data_t read_port(reg_idx_t idx);
        if (idx == '0) return '0;
        if (ex1_valid && (ex1_rd == idx)) return ex1_data; // the younger result is newer.
        if (ex0_valid && (ex0_rd == idx)) return ex0_data;
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ex0_valid && (ex0_rd != '0)) begin
                regs[ex0_rd] <= ex0_data;
            end
            if (ex1_valid && (ex1_rd != '0)) begin
                regs[ex1_rd] <= ex1_data; // last write wins on a shared rd.
            end
        end
    end

    always_comb begin
        rdata_1a = read_port(rs1_a);
        rdata_2a = read_port(rs2_a);
        rdata_1b = read_port(rs1_b);
        rdata_2b = read_port(rs2_b);
    end

    assign wb0_valid = ex0_valid;
    assign wb0_rd    = ex0_rd;
    assign wb0_data  = ex0_data;
    assign wb1_valid = ex1_valid;
    assign wb1_rd    = ex1_rd;
    assign wb1_data  = ex1_data;

endmodule

// File: src/dual_issue_core.sv
`timescale 1ns/100ps

module dual_issue_core #(
    parameter int depth = core_pkg::default_depth
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               line_valid,
    input  core_pkg::line_t    line,
    input  logic               hold,
    output logic               full,
    output logic               wb0_valid,
    output core_pkg::reg_idx_t wb0_rd,
    output core_pkg::data_t    wb0_data,
    output logic               wb1_valid,
    output core_pkg::reg_idx_t wb1_rd,
    output core_pkg::data_t    wb1_data
);
    import core_pkg::*;

    instr_t   head0, head1;
    logic     head0_valid, head1_valid;
    logic [1:0] issue_count;
    reg_idx_t rs1_a, rs2_a, rs1_b, rs2_b;
    data_t    rdata_1a, rdata_2a, rdata_1b, rdata_2b;
    logic     valid_a, valid_b;
    opcode_e  op_a, op_b;
    reg_idx_t rd_a, rd_b;
    data_t    x_a, y_a, x_b, y_b;
    logic     ex0_valid, ex1_valid;
    reg_idx_t ex0_rd, ex1_rd;
    data_t    ex0_data, ex1_data;

    fetch_buffer #(.depth(depth)) fetch_buffer_inst (
        .clk, .rstn, .line_valid, .line, .issue_count,
        .head0, .head1, .head0_valid, .head1_valid, .full
    );

    issue_decode issue_decode_inst (
        .head0, .head1, .head0_valid, .head1_valid, .hold,
        .rdata_1a, .rdata_2a, .rdata_1b, .rdata_2b,
        .issue_count, .rs1_a, .rs2_a, .rs1_b, .rs2_b,
        .valid_a, .valid_b, .op_a, .op_b, .rd_a, .rd_b,
        .x_a, .y_a, .x_b, .y_b
    );

    alu_execute alu_execute_inst (
        .clk, .rstn, .valid_a, .valid_b, .op_a, .op_b, .rd_a, .rd_b,
        .x_a, .y_a, .x_b, .y_b,
        .ex0_valid, .ex0_rd, .ex0_data, .ex1_valid, .ex1_rd, .ex1_data
    );

    reg_result reg_result_inst (
        .clk, .rstn, .ex0_valid, .ex0_rd, .ex0_data, .ex1_valid, .ex1_rd, .ex1_data,
        .rs1_a, .rs2_a, .rs1_b, .rs2_b, .rdata_1a, .rdata_2a, .rdata_1b, .rdata_2b,
        .wb0_valid, .wb0_rd, .wb0_data, .wb1_valid, .wb1_rd, .wb1_data
    );

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

// File: verification/dual_issue_tb.sv
`timescale 1ns/100ps

module dual_issue_tb;
    import core_pkg::*;

    localparam int depth = 16;

    logic     clk;
    logic     rstn;
    logic     line_valid;
    line_t    line;
    logic     hold;
    logic     full;
    logic     wb0_valid;
    logic     wb1_valid;
    reg_idx_t wb0_rd;
    reg_idx_t wb1_rd;
    data_t    wb0_data;
    data_t    wb1_data;

    integer   seed;
    int       errors;
    int       pass_count;
    int       fail_count;
    int       retired;
    int       expected_total;
    logic     freeze;
    data_t    model_regs [16];
    logic     prev_writes;
    reg_idx_t prev_rd;
    reg_idx_t exp_rd  [$];
    data_t    exp_val [$];
    logic     exp_dep [$];

    tb_clock tb_clock_inst (.clk(clk), .rstn(rstn));

    dual_issue_core #(.depth(depth)) dual_issue_core_inst (
        .clk, .rstn, .line_valid, .line, .hold, .full,
        .wb0_valid, .wb0_rd, .wb0_data, .wb1_valid, .wb1_rd, .wb1_data
    );

    // runs one instruction through the model in program order.
    task automatic model_instr(input instr_t ins);
        logic [3:0] op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        data_t      x;
        data_t      y;
        data_t      val;
        logic       regreg;
        logic       writes;
        op     = ins[31] ? 4'd0 : ins[31:28];
        rd     = ins[27:24];
        rs1    = ins[23:20];
        rs2    = ins[19:16];
        regreg = (op >= 4'd1) && (op <= 4'd5);
        x      = model_regs[rs1];
        y      = model_regs[rs2];
        if (op == 4'd6) y = {{16{ins[15]}}, ins[15:0]};
        if (op == 4'd7) y = {ins[15:0], 16'h0000};
        case (op)
            4'd1, 4'd6: val = x + y;
            4'd2:       val = x - y;
            4'd3:       val = x & y;
            4'd4:       val = x | y;
            4'd5:       val = x ^ y;
            default:    val = y;
        endcase
        writes = (op != 4'd0) && (rd != 4'd0);
        if (writes) begin
            model_regs[rd] = val;
            exp_rd.push_back(rd);
            exp_val.push_back(val);
            exp_dep.push_back(prev_writes && ((rs1 == prev_rd) || (regreg && rs2 == prev_rd)));
            expected_total++;
        end
        prev_writes = writes;
        prev_rd     = rd;
    endtask

    function automatic instr_t random_instr();
        logic [3:0] op;
        op = 4'($unsigned($random(seed)) % 9);
        if (op == 4'd8) op = 4'd11; // one undefined code.
        return {op, 4'($unsigned($random(seed)) % 4), 4'($unsigned($random(seed)) % 4),
                4'($unsigned($random(seed)) % 4), 16'($random(seed))};
    endfunction

    task automatic send_line(input line_t l);
        int guard;
        guard = 0;
        while (full && guard < 200) begin
            @(posedge clk);
            #1;
            guard++;
        end
        if (full) begin
            $display("timeout while waiting for the fetch queue to leave full");
            errors++;
        end else begin
            line_valid = 1'b1;
            line       = l;
            for (int k = 0; k < 4; k++) model_instr(l[32*k +: 32]);
            @(posedge clk);
            #1 line_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int guard;
        guard = 0;
        while (exp_rd.size() != 0 && guard < 500) begin
            @(posedge clk);
            #1;
            guard++;
        end
        if (exp_rd.size() != 0) begin
            $display("timeout while waiting for %0d results to retire", exp_rd.size());
            errors++;
        end
        repeat (5) @(posedge clk); // lets any extra record show up.
        #1;
        if (retired != expected_total) begin
            $display("Fail %0t: %0d records retired, model expects %0d",
                     $time, retired, expected_total);
            errors++;
        end
    endtask

    task automatic check_record(input reg_idx_t rd, input data_t data, input logic slot1);
        if (exp_rd.size() == 0) begin
            $display("Fail %0t: record rd %0d retired with nothing expected", $time, rd);
            errors++;
        end else begin
            if (rd != exp_rd[0] || data != exp_val[0]) begin
                $display("Fail %0t: got rd %0d data %h, expected rd %0d data %h",
                         $time, rd, data, exp_rd[0], exp_val[0]);
                errors++;
            end
            if (slot1 && exp_dep[0]) begin
                $display("Fail %0t: dependent pair retired together", $time);
                errors++;
            end
            void'(exp_rd.pop_front());
            void'(exp_val.pop_front());
            void'(exp_dep.pop_front());
        end
        retired++;
    endtask

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (rstn) begin
            if (wb1_valid && !wb0_valid) begin
                $display("Fail %0t: slot 1 retired without slot 0", $time);
                errors++;
            end
            if (freeze && wb0_valid) begin
                $display("Fail %0t: a record retired while hold was high", $time);
                errors++;
            end
            if (wb0_valid) check_record(wb0_rd, wb0_data, 1'b0);
            if (wb1_valid) check_record(wb1_rd, wb1_data, 1'b1);
        end
    end

    task automatic report(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: passed", name);
            pass_count++;
        end else begin
            $display("test %s: failed", name);
            fail_count++;
        end
    endtask

    initial begin
        int     e0;
        int     accepted;
        int     guard;
        line_t  l;
        seed = 32'h562e_4c50;
        line_valid = 1'b0;
        line = '0;
        hold = 1'b0;
        freeze = 1'b0;
        errors = 0;
        pass_count = 0;
        fail_count = 0;
        retired = 0;
        expected_total = 0;
        prev_writes = 1'b0;
        prev_rd = '0;
        for (int i = 0; i < 16; i++) model_regs[i] = '0;

        e0 = errors;
        guard = 0;
        while (!rstn && guard < 50) begin
            @(negedge clk);
            if (full || wb0_valid || wb1_valid) begin
                $display("Fail %0t: outputs active during reset", $time);
                errors++;
            end
            guard++;
        end
        if (!rstn) begin
            $display("timeout while waiting for reset to be released");
            errors++;
        end
        @(posedge clk);
        #1;
        if (full || wb0_valid || wb1_valid) begin
            $display("Fail %0t: outputs active after reset", $time);
            errors++;
        end
        report("reset", e0);

        e0 = errors;
        for (int n = 0; n < 40; n++) begin
            for (int k = 0; k < 4; k++) l[32*k +: 32] = random_instr();
            send_line(l);
        end
        wait_drain();
        report("in_order_and_pairing", e0);

        e0 = errors;
        for (int n = 0; n < 6; n++) begin
            for (int k = 0; k < 4; k++) begin
                l[32*k +: 32] = {4'd6, 4'd5, 4'd5, 4'd0, 16'($random(seed))};
            end
            send_line(l);
        end
        wait_drain();
        report("forwarding", e0);

        e0 = errors;
        hold = 1'b1;
        freeze = 1'b1;
        accepted = 0;
        guard = 0;
        while (!full && guard < 50) begin
            for (int k = 0; k < 4; k++) l[32*k +: 32] = random_instr();
            send_line(l);
            accepted++;
            guard++;
        end
        if (!full) begin
            $display("timeout while waiting for the fetch queue to report full");
            errors++;
        end
        if (accepted != depth / 4) begin
            $display("Fail %0t: %0d lines accepted before full, expected %0d",
                     $time, accepted, depth / 4);
            errors++;
        end
        repeat (20) @(posedge clk);
        #1;
        freeze = 1'b0;
        hold = 1'b0;
        wait_drain();
        report("back_pressure", e0);

        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
src/core_pkg.sv
src/fetch_buffer.sv
src/issue_decode.sv
src/alu_execute.sv
src/reg_result.sv
src/dual_issue_core.sv
verification/tb_clock.sv
verification/dual_issue_tb.sv
